// ==== src/cache_defs.svh ====
// Geometry macros of the data cache, included by the package and by modules that size arrays
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// --------------------
// Line geometry
// --------------------

// Words held in one cache line, a power of two
`define CACHE_BLOCK_WORDS 4

// Sets in each of the two ways, a power of two
// Small on purpose so that lines conflict often
`define CACHE_SETS 2

`endif

// ==== src/cachePkg.sv ====
// Shared types of the data cache, imported by every block of the cache
`include "cache_defs.svh"

package cachePkg;

    // --------------------
    // Field types
    // --------------------

    // Byte address and data word of the core and the bus
    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    // One enable per byte lane of a store
    typedef logic [3:0]  byteMaskT;

    // Address split into tag, set and word offset, above the byte offset
    typedef logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] offsetT;
    typedef logic [$clog2(`CACHE_SETS)-1:0]        setT;
    typedef logic [31-2-$clog2(`CACHE_BLOCK_WORDS)-$clog2(`CACHE_SETS):0] tagT;

    // --------------------
    // Structs
    // --------------------

    // Request from the memory stage, address already split
    typedef struct packed {
        tagT      tag;
        setT      set;
        offsetT   offset;
        logic [1:0] byteOff;
        logic     read;
        logic     write;
        byteMaskT mask;
        wordT     wdata;
    } cacheReqT;

    // One word command on the memory bus
    typedef struct packed {
        addrT addr;
        wordT wdata;
        logic write;
    } busCmdT;

    // Miss handling states, also used as the burst mode of the sequencer
    typedef enum logic [2:0] {IDLE, WRITEBACK, FILL, BYPASS, RETRY} ctrlStateT;

endpackage

// ==== src/cacheRequest.sv ====
// Input side of the data cache; splits the core address and merges store bytes
`timescale 1ns/1ps

module cacheRequest (
    input  cachePkg::addrT     A,
    input  cachePkg::wordT     WD,
    input  cachePkg::byteMaskT ByteMask,
    input  logic               MemWriteM,
    input  logic               MemtoRegM,
    input  cachePkg::wordT     hitWord,
    output cachePkg::cacheReqT req,
    output cachePkg::wordT     storeWord
);
    import cachePkg::*;

    // --------------------
    // Request fields
    // --------------------

    always_comb begin
        // Tag, set, word offset and byte offset, high to low
        {req.tag, req.set, req.offset, req.byteOff} = A;
        // Access kind straight from the memory stage
        req.read  = MemtoRegM;
        req.write = MemWriteM;
        // Raw store data and its lanes
        req.mask  = ByteMask;
        req.wdata = WD;
    end

    // --------------------
    // Store merge
    // --------------------

    // Start from the word in the line so that unmasked bytes survive
    // Masked lanes take the new byte from the core
    always_comb begin
        storeWord = hitWord;
        for (int b = 0; b < $bits(byteMaskT); b++) begin
            if (req.mask[b]) begin
                storeWord[8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
    end

    // A full mask gives WD itself
    // A load ignores storeWord, the memory writes it only on a store hit
    // In bypass the merge is over the cached copy, or zero when the line is absent

endmodule

// ==== src/cacheMemory.sv ====
// Two-way storage of the data cache with hit detection, victim choice and LRU state
`timescale 1ns/1ps
`include "cache_defs.svh"

module cacheMemory (
    input  logic               clk,
    input  logic               rstN,
    input  cachePkg::cacheReqT req,
    input  cachePkg::wordT     storeWord,
    input  logic               storeEn,
    input  logic               fillEn,
    input  cachePkg::wordT     fillWord,
    input  cachePkg::offsetT   fillIndex,
    output logic               hit,
    output cachePkg::wordT     hitWord,
    output logic               victimDirty,
    output cachePkg::tagT      victimTag,
    output cachePkg::wordT     victimWord
);
    import cachePkg::*;

    // --------------------
    // Storage
    // --------------------

    // Way, set, word
    wordT dataMem [2][`CACHE_SETS][`CACHE_BLOCK_WORDS];
    tagT  tagMem  [2][`CACHE_SETS];

    // Per set, one bit per way
    logic [`CACHE_SETS-1:0][1:0] validQ;
    logic [`CACHE_SETS-1:0][1:0] dirtyQ;
    // Per set, the way to evict next
    logic [`CACHE_SETS-1:0]      lruQ;

    logic [1:0] hitWay;
    logic       hitIdx;
    logic       victimIdx;
    logic       fillLast;
    logic       access;

    // --------------------
    // Lookup
    // --------------------

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hitWay[w] = validQ[req.set][w] && (tagMem[w][req.set] == req.tag);
        end
    end

    assign hit     = |hitWay;
    assign hitIdx  = hitWay[1];
    assign hitWord = hit ? dataMem[hitIdx][req.set][req.offset] : '0;
    assign access  = req.read || req.write;

    // Invalid way first, else the least recently used one
    // Stable for the whole miss since neither valid nor LRU moves before the last fill word
    always_comb begin
        if (!validQ[req.set][0]) begin
            victimIdx = 1'b0;
        end else if (!validQ[req.set][1]) begin
            victimIdx = 1'b1;
        end else begin
            victimIdx = lruQ[req.set];
        end
    end

    assign victimDirty = validQ[req.set][victimIdx] && dirtyQ[req.set][victimIdx];
    assign victimTag   = tagMem[victimIdx][req.set];
    // Word at the burst index, for the writeback
    assign victimWord  = dataMem[victimIdx][req.set][fillIndex];

    // Line becomes valid only with its last word
    assign fillLast = fillEn && (fillIndex == offsetT'(`CACHE_BLOCK_WORDS - 1));

    // --------------------
    // Updates
    // --------------------

    always_ff @(posedge clk) begin
        if (storeEn) begin
            dataMem[hitIdx][req.set][req.offset] <= storeWord;
        end
        if (fillEn) begin
            dataMem[victimIdx][req.set][fillIndex] <= fillWord;
        end
        if (fillLast) begin
            tagMem[victimIdx][req.set] <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= '0;
            dirtyQ <= '0;
            lruQ   <= '0;
        end else begin
            // Completed fill, clean and most recently used
            if (fillLast) begin
                validQ[req.set][victimIdx] <= 1'b1;
                dirtyQ[req.set][victimIdx] <= 1'b0;
                lruQ[req.set]              <= ~victimIdx;
            end
            if (storeEn) begin
                dirtyQ[req.set][hitIdx] <= 1'b1;
            end
            // Any hit makes the other way the victim
            if (hit && access) begin
                lruQ[req.set] <= ~hitIdx;
            end
        end
    end

    // Fill only writes a tag that missed in both ways
    assert property (@(posedge clk) disable iff (!rstN) !(hitWay[0] && hitWay[1]));

    // A store hit and a fill word never share a cycle
    assert property (@(posedge clk) disable iff (!rstN) !(storeEn && fillEn));

endmodule

// ==== src/cacheController.sv ====
// Miss state machine of the data cache; drives Stall, the memory write strobes and the bus mode
`timescale 1ns/1ps

module cacheController (
    input  logic                clk,
    input  logic                rstN,
    input  logic                enable,
    input  cachePkg::cacheReqT  req,
    input  logic                hit,
    input  logic                victimDirty,
    input  logic                wordDone,
    input  logic                lineDone,
    output logic                Stall,
    output logic                storeEn,
    output logic                fillEn,
    output cachePkg::ctrlStateT burstMode,
    output logic                busActive
);
    import cachePkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    // Bypass word just finished so the core is released for one cycle
    logic      bypassDone;
    logic      access;

    assign access = req.read || req.write;

    // --------------------
    // State register
    // --------------------

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= IDLE;
            bypassDone <= 1'b0;
        end else begin
            state      <= nextState;
            bypassDone <= (state == BYPASS) && wordDone;
        end
    end

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        nextState = state;
        Stall     = 1'b1;
        storeEn   = 1'b0;
        case (state)
            IDLE: begin
                Stall = 1'b0;
                if (access && !enable && !bypassDone) begin
                    // Uncached access takes one bus word
                    Stall     = 1'b1;
                    nextState = BYPASS;
                end else if (access && enable && !hit) begin
                    // Dirty victim goes out before the new line comes in
                    Stall     = 1'b1;
                    nextState = victimDirty ? WRITEBACK : FILL;
                end else if (enable && hit) begin
                    // Store hit lands on this edge
                    storeEn = req.write;
                end
            end
            WRITEBACK: begin
                if (lineDone) begin
                    nextState = FILL;
                end
            end
            FILL: begin
                if (lineDone) begin
                    nextState = RETRY;
                end
            end
            BYPASS: begin
                // Stall drops in the cycle after the word
                if (wordDone) begin
                    nextState = IDLE;
                end
            end
            RETRY: begin
                // Line is in place so the access replays from IDLE
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // --------------------
    // Outputs
    // --------------------

    // Each fill word is written as it arrives
    assign fillEn    = (state == FILL) && wordDone;
    assign burstMode = state;
    assign busActive = (state == WRITEBACK) || (state == FILL) || (state == BYPASS);

    // The freshly filled line hits when the access is replayed
    assert property (@(posedge clk) disable iff (!rstN) (state == RETRY) |-> hit);

endmodule

// ==== src/busSequencer.sv ====
// Output side of the data cache; counts line bursts and forms each bus word command
`timescale 1ns/1ps

module busSequencer (
    input  logic                clk,
    input  logic                rstN,
    input  cachePkg::cacheReqT  req,
    input  cachePkg::wordT      storeWord,
    input  cachePkg::tagT       victimTag,
    input  cachePkg::wordT      victimWord,
    input  cachePkg::ctrlStateT burstMode,
    input  logic                busActive,
    input  logic                BusReady,
    output cachePkg::busCmdT    busCmd,
    output logic                HRequestM,
    output cachePkg::offsetT    wordIndex,
    output logic                wordDone,
    output logic                lineDone
);
    import cachePkg::*;

    // Writeback or fill, as opposed to a single bypass word
    logic burst;

    assign burst     = (burstMode == WRITEBACK) || (burstMode == FILL);
    assign HRequestM = busActive;
    // Transfer done when request and ready meet on an edge
    assign wordDone  = busActive && BusReady;
    assign lineDone  = wordDone && burst && (wordIndex == '1);

    // --------------------
    // Word counter
    // --------------------

    // Wraps to zero after the last word, ready for the next burst
    // Holds while BusReady is low
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wordIndex <= '0;
        end else if (wordDone && burst) begin
            wordIndex <= wordIndex + 1'b1;
        end
    end

    // --------------------
    // Bus command
    // --------------------

    always_comb begin
        busCmd.addr  = {req.tag, req.set, req.offset, req.byteOff};
        busCmd.wdata = storeWord;
        busCmd.write = 1'b0;
        case (burstMode)
            WRITEBACK: begin
                // Old line address from the victim tag
                busCmd.addr  = {victimTag, req.set, wordIndex, 2'b00};
                busCmd.wdata = victimWord;
                busCmd.write = 1'b1;
            end
            FILL: begin
                busCmd.addr = {req.tag, req.set, wordIndex, 2'b00};
            end
            BYPASS: begin
                busCmd.write = req.write;
            end
            default: begin
                busCmd.write = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/dataCache.sv ====
// Top of the two-way write-back data cache, between the memory stage and the memory bus
`timescale 1ns/1ps

module dataCache (
    input  logic               clk,
    input  logic               rstN,
    input  logic               enable,
    input  logic               MemWriteM,
    input  logic               MemtoRegM,
    input  cachePkg::addrT     A,
    input  cachePkg::wordT     WD,
    input  cachePkg::byteMaskT ByteMask,
    input  cachePkg::wordT     HRData,
    input  logic               BusReady,
    output cachePkg::wordT     RD,
    output logic               Stall,
    output cachePkg::addrT     HAddr,
    output cachePkg::wordT     HWData,
    output logic               HRequestM,
    output logic               HWriteM
);
    import cachePkg::*;

    cacheReqT  req;
    wordT      storeWord;
    wordT      hitWord;
    wordT      victimWord;
    wordT      bypassWord;
    tagT       victimTag;
    offsetT    wordIndex;
    ctrlStateT burstMode;
    busCmdT    busCmd;
    logic      hit;
    logic      victimDirty;
    logic      storeEn;
    logic      fillEn;
    logic      busActive;
    logic      wordDone;
    logic      lineDone;

    // --------------------
    // Blocks
    // --------------------

    cacheRequest reqUnit (
        .A(A), .WD(WD), .ByteMask(ByteMask), .MemWriteM(MemWriteM),
        .MemtoRegM(MemtoRegM), .hitWord(hitWord), .req(req), .storeWord(storeWord)
    );

    // Fill words come straight off the bus
    cacheMemory memUnit (
        .clk(clk), .rstN(rstN), .req(req), .storeWord(storeWord), .storeEn(storeEn),
        .fillEn(fillEn), .fillWord(HRData), .fillIndex(wordIndex), .hit(hit),
        .hitWord(hitWord), .victimDirty(victimDirty), .victimTag(victimTag),
        .victimWord(victimWord)
    );

    cacheController ctrlUnit (
        .clk(clk), .rstN(rstN), .enable(enable), .req(req), .hit(hit),
        .victimDirty(victimDirty), .wordDone(wordDone), .lineDone(lineDone),
        .Stall(Stall), .storeEn(storeEn), .fillEn(fillEn), .burstMode(burstMode),
        .busActive(busActive)
    );

    busSequencer seqUnit (
        .clk(clk), .rstN(rstN), .req(req), .storeWord(storeWord), .victimTag(victimTag),
        .victimWord(victimWord), .burstMode(burstMode), .busActive(busActive),
        .BusReady(BusReady), .busCmd(busCmd), .HRequestM(HRequestM),
        .wordIndex(wordIndex), .wordDone(wordDone), .lineDone(lineDone)
    );

    // --------------------
    // Core and bus outputs
    // --------------------

    // Bypass load data, held for the cycle Stall drops
    always_ff @(posedge clk) begin
        if (wordDone && (burstMode == BYPASS)) begin
            bypassWord <= HRData;
        end
    end

    assign RD      = enable ? hitWord : bypassWord;
    assign HAddr   = busCmd.addr;
    assign HWData  = busCmd.wdata;
    assign HWriteM = busCmd.write;

endmodule

// ==== test/busMemory.sv ====
// Testbench memory behind the cache's word bus, with random BusReady stalls of bounded length
`timescale 1ns/1ps

module busMemory #(
    parameter int WORDS     = 64,
    parameter int STALL_MAX = 4
) (
    input  logic           clk,
    input  logic           rstN,
    input  cachePkg::addrT HAddr,
    input  cachePkg::wordT HWData,
    input  logic           HRequestM,
    input  logic           HWriteM,
    input  logic           readyCoin,
    output cachePkg::wordT HRData,
    output logic           BusReady
);
    import cachePkg::*;

    // Contents are loaded by the testbench before reset ends
    wordT mem [WORDS];
    int   lowCount;
    logic [$clog2(WORDS)-1:0] index;

    assign index  = HAddr[2 +: $clog2(WORDS)];
    // Read data valid in the cycle of the transfer
    assign HRData = mem[index];

    // --------------------
    // Back-pressure
    // --------------------

    // Ready follows the coin, forced high after STALL_MAX - 1 low cycles
    always @(posedge clk) begin
        if (!rstN) begin
            BusReady <= 1'b0;
            lowCount <= 0;
        end else if (readyCoin || lowCount == STALL_MAX - 1) begin
            BusReady <= 1'b1;
            lowCount <= 0;
        end else begin
            BusReady <= 1'b0;
            lowCount <= lowCount + 1;
        end
    end

    // Write lands on the edge where request and ready meet
    always @(posedge clk) begin
        if (HRequestM && BusReady && HWriteM) begin
            mem[index] <= HWData;
        end
    end

endmodule

// ==== test/tbDataCache.sv ====
// Testbench of the data cache; random loads and stores checked against a flat memory model
`timescale 1ns/1ps
`include "cache_defs.svh"

module tbDataCache;
    import cachePkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int LINE_WORDS   = `CACHE_BLOCK_WORDS;
    localparam int SETS         = `CACHE_SETS;
    // Cached accesses use four tags, bypass accesses the region just above
    localparam int CACHED_WORDS = 4 * SETS * LINE_WORDS;
    localparam int MEM_WORDS    = 2 * CACHED_WORDS;
    localparam int STALL_BOUND  = 4;
    localparam int N_CACHED     = 300;
    localparam int N_BYPASS     = 60;
    localparam int N_AGAIN      = 100;
    // Writeback and fill at the stall bound, then retry, release and gap
    localparam int MISS_CYCLES  = 2 * LINE_WORDS * STALL_BOUND + 4;
    localparam int TIMEOUT_NS   =
        (RESET_CYCLES + 4 + (N_CACHED + N_BYPASS + N_AGAIN) * MISS_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic     clk;
    logic     rstN;
    logic     enable;
    logic     MemWriteM;
    logic     MemtoRegM;
    addrT     A;
    wordT     WD;
    byteMaskT ByteMask;
    wordT     HRData;
    logic     BusReady;
    wordT     RD;
    logic     Stall;
    addrT     HAddr;
    wordT     HWData;
    logic     HRequestM;
    logic     HWriteM;
    logic     readyCoin;

    // Reference model, memory as the core sees it
    wordT        modelMem [MEM_WORDS];
    // Per set, line tags with the most recent first
    int          lruList [SETS][2];
    int          lruCount [SETS];
    bit          lineDirty [4 * SETS];
    logic [31:0] stimState;
    logic [31:0] readyState;
    // Bus transfers of the current access
    addrT        xferAddr [$];
    wordT        xferData [$];
    logic        xferWrite [$];
    bit          reqSeen;
    int          errorCount;
    int          testCount;
    int          failCount;

    dataCache i_dut (
        .clk(clk), .rstN(rstN), .enable(enable), .MemWriteM(MemWriteM),
        .MemtoRegM(MemtoRegM), .A(A), .WD(WD), .ByteMask(ByteMask), .HRData(HRData),
        .BusReady(BusReady), .RD(RD), .Stall(Stall), .HAddr(HAddr), .HWData(HWData),
        .HRequestM(HRequestM), .HWriteM(HWriteM)
    );

    busMemory #(.WORDS(MEM_WORDS), .STALL_MAX(STALL_BOUND)) busMem (
        .clk(clk), .rstN(rstN), .HAddr(HAddr), .HWData(HWData), .HRequestM(HRequestM),
        .HWriteM(HWriteM), .readyCoin(readyCoin), .HRData(HRData), .BusReady(BusReady)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------

    // One Galois step, the bit taken is the lsb before it
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Initial memory word, mixes every address bit
    function automatic wordT patternWord(input int idx);
        return ((32'(idx) + 1) * 32'h9E37_79B9) ^ (32'(idx) << 12);
    endfunction

    task automatic draw(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], stimState[0]};
            stimState = lfsrStep(stimState);
        end
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
            errorCount++;
        end
    endtask

    // Ready is low only when both draws are zero
    always @(posedge clk) begin : readyDraw
        logic first;
        first = readyState[0];
        readyState = lfsrStep(readyState);
        readyCoin <= first | readyState[0];
        readyState = lfsrStep(readyState);
    end

    // Samples before the edge updates, so every completed word is seen once
    always @(posedge clk) begin
        if (rstN && HRequestM) begin
            reqSeen = 1'b1;
            if (BusReady) begin
                xferAddr.push_back(HAddr);
                xferData.push_back(HWriteM ? HWData : HRData);
                xferWrite.push_back(HWriteM);
            end
        end
    end

    // --------------------
    // One access
    // --------------------

    // Entered right after a rising edge, leaves one idle cycle behind it
    task automatic runAccess(input logic en, input logic isStore, input int word,
                             input byteMaskT mask, input wordT data);
        int line;
        int set;
        int tag;
        int victim;
        int wbWords;
        int lineBase;
        bit expectHit;
        line = word / LINE_WORDS;
        set  = line % SETS;
        tag  = line / SETS;
        expectHit = (lruCount[set] > 0 && lruList[set][0] == tag) ||
                    (lruCount[set] > 1 && lruList[set][1] == tag);
        victim  = -1;
        wbWords = 0;
        // Full set evicts its older line
        if (en && !expectHit && lruCount[set] == 2) begin
            victim = lruList[set][1];
            wbWords = lineDirty[victim * SETS + set] ? LINE_WORDS : 0;
        end
        A         <= addrT'(word * 4);
        WD        <= data;
        ByteMask  <= mask;
        MemWriteM <= isStore;
        MemtoRegM <= !isStore;
        enable    <= en;
        xferAddr.delete();
        xferData.delete();
        xferWrite.delete();
        reqSeen = 1'b0;
        // Inputs held until Stall is low at an edge
        do begin
            @(posedge clk);
        end while (Stall);
        if (!isStore) begin
            checkValue("load data", RD, modelMem[word]);
        end
        MemWriteM <= 1'b0;
        MemtoRegM <= 1'b0;
        if (!en) begin
            checkValue("bypass transfer count", xferAddr.size(), 1);
            if (xferAddr.size() > 0) begin
                checkValue("bypass address", xferAddr[0], word * 4);
                checkValue("bypass write flag", xferWrite[0], isStore);
                checkValue("bypass bus data", xferData[0], isStore ? data : modelMem[word]);
            end
        end else if (expectHit) begin
            checkValue("bus request on hit", reqSeen, 0);
        end else begin
            // Dirty victim words first, then the new line
            checkValue("miss transfer count", xferAddr.size(), wbWords + LINE_WORDS);
            for (int i = 0; i < xferAddr.size() && i < wbWords + LINE_WORDS; i++) begin
                lineBase = ((i < wbWords ? victim : tag) * SETS + set) * LINE_WORDS;
                checkValue("miss write flag", xferWrite[i], i < wbWords);
                checkValue("miss address", xferAddr[i], (lineBase + i % LINE_WORDS) * 4);
                checkValue("miss bus data", xferData[i], modelMem[lineBase + i % LINE_WORDS]);
            end
        end
        // Model update after the checks
        if (en) begin
            if (expectHit && lruList[set][0] != tag) begin
                lruList[set][1] = lruList[set][0];
                lruList[set][0] = tag;
            end else if (!expectHit) begin
                if (victim >= 0) begin
                    lineDirty[victim * SETS + set] = 1'b0;
                end
                lruList[set][1] = lruList[set][0];
                lruList[set][0] = tag;
                lruCount[set] = (lruCount[set] < 2) ? lruCount[set] + 1 : 2;
                lineDirty[line] = 1'b0;
            end
            if (isStore) begin
                lineDirty[line] = 1'b1;
            end
        end
        if (isStore) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    modelMem[word][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        @(posedge clk);
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic runCached(input int count);
        logic [31:0] isStore;
        logic [31:0] word;
        logic [31:0] mask;
        logic [31:0] data;
        repeat (count) begin
            draw(1, isStore);
            draw($clog2(CACHED_WORDS), word);
            draw(4, mask);
            draw(32, data);
            runAccess(1'b1, isStore[0], int'(word), mask[3:0], data);
        end
    endtask

    // Uncached region only, full words since the bus has no byte lanes
    task automatic runBypass(input int count);
        logic [31:0] isStore;
        logic [31:0] word;
        logic [31:0] data;
        repeat (count) begin
            draw(1, isStore);
            draw($clog2(CACHED_WORDS), word);
            draw(32, data);
            runAccess(1'b0, isStore[0], CACHED_WORDS + int'(word), 4'hF, data);
        end
    endtask

    task automatic reportTest(input string name, input int startErrors, input int accesses);
        testCount++;
        if (errorCount == startErrors) begin
            $display("Test %s passed, %0d accesses", name, accesses);
        end else begin
            failCount++;
            $display("Test %s failed with %0d errors", name, errorCount - startErrors);
        end
    endtask

    initial begin
        int startErrors;
        rstN      <= 1'b0;
        enable    <= 1'b1;
        MemWriteM <= 1'b0;
        MemtoRegM <= 1'b0;
        A         <= '0;
        WD        <= '0;
        ByteMask  <= '0;
        readyCoin <= 1'b0;
        stimState  = 32'd39;
        readyState = 32'd39;
        errorCount = 0;
        testCount  = 0;
        failCount  = 0;
        reqSeen    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            modelMem[i] = patternWord(i);
            busMem.mem[i] = patternWord(i);
        end
        for (int s = 0; s < SETS; s++) begin
            lruCount[s] = 0;
        end
        for (int l = 0; l < 4 * SETS; l++) begin
            lineDirty[l] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        startErrors = errorCount;
        checkValue("Stall after reset", Stall, 0);
        checkValue("HRequestM after reset", HRequestM, 0);
        checkValue("HWriteM after reset", HWriteM, 0);
        reportTest("reset state", startErrors, 0);
        startErrors = errorCount;
        runCached(N_CACHED);
        reportTest("cached random", startErrors, N_CACHED);
        startErrors = errorCount;
        runBypass(N_BYPASS);
        reportTest("bypass random", startErrors, N_BYPASS);
        // Lines cached before the bypass run must be intact
        startErrors = errorCount;
        runCached(N_AGAIN);
        reportTest("cached after bypass", startErrors, N_AGAIN);
        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget covers every access at its worst miss length
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT kept Stall high past the time budget of all tests");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+src
src/cachePkg.sv
src/cacheRequest.sv
src/cacheMemory.sv
src/cacheController.sv
src/busSequencer.sv
src/dataCache.sv
test/busMemory.sv
test/tbDataCache.sv

// ==== Bender.yml ====
package:
  name: data_cache

sources:
  - include_dirs:
      - src
    files:
      - src/cachePkg.sv
      - src/cacheRequest.sv
      - src/cacheMemory.sv
      - src/cacheController.sv
      - src/busSequencer.sv
      - src/dataCache.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/busMemory.sv
      - test/tbDataCache.sv
